//--- rtl/pov_pkg.sv
package pov_pkg;

    // Slice geometry in pixels
    localparam int row_size = 80;
    localparam int column_size = 48;
    localparam int image_size = row_size * column_size;
    localparam int idx_width = $clog2(image_size);

    // Panel geometry
    localparam int multiplexing = 8;
    localparam int led_per_driver = 16;
    localparam int drivers_per_row = 10;
    localparam int driver_rows = 3;
    localparam int num_drivers = drivers_per_row * driver_rows;

    // Bit slots per LED colour, MSB first
    localparam int poker_mode = 9;

    // Colour order within one LED
    localparam logic [1:0] colour_red = 2'd0;
    localparam logic [1:0] colour_green = 2'd1;
    localparam logic [1:0] colour_blue = 2'd2;

    // External RAM
    localparam int ram_addr_width = 32;
    localparam int unsigned ram_base = 0;

    // Credit loops
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int credit_width = $clog2(fifo_depth + 1);
    localparam int ext_credit_width = 8;

    typedef logic [7:0] slice_pos_t;

    // RGB565, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // One RAM word, stored raw and decoded by colour
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb;
    } pixel_t;

    typedef struct packed {
        logic [num_drivers-1:0] bits;
        logic                   last_of_plane;
    } scan_word_t;

    // Drivers pair up, even one on even columns and odd one on odd columns
    // Each pair covers 2 x multiplexing columns, each driver row 16 buffer rows
    function automatic logic [idx_width-1:0] driver_base(input int unsigned i);
        int unsigned pair;
        int unsigned side;
        int unsigned row;
        pair = (i % drivers_per_row) / 2;
        side = i % 2;
        row = i / drivers_per_row;
        return idx_width'(2 * multiplexing * pair + side + row * row_size * led_per_driver);
    endfunction

endpackage

//--- rtl/encoder_tracker.sv
`timescale 1ns/1ps

module encoder_tracker
    import pov_pkg::*;
(
    input  logic       clk_33,
    input  logic       nrst,
    input  logic       enc_sync,
    input  slice_pos_t enc_position,
    output logic       start,
    output slice_pos_t pos
);

    // Two synchronizer stages plus the edge register
    logic sync_q1;
    logic sync_q2;
    logic sync_q3;
    logic rise;

    // Rising edge on the synchronized strobe
    assign rise = sync_q2 && !sync_q3;

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            sync_q3 <= 1'b0;
            start <= 1'b0;
            pos <= '0;
        end else begin
            sync_q1 <= enc_sync;
            sync_q2 <= sync_q1;
            sync_q3 <= sync_q2;
            start <= rise;
            // Position is stable around the strobe
            if (rise) begin
                pos <= enc_position;
            end
        end
    end

    // One slice request per strobe edge
    a_start_single: assert property (@(posedge clk_33) disable iff (!nrst) start |=> !start);

endmodule

//--- rtl/slice_fetch.sv
`timescale 1ns/1ps

module slice_fetch
    import pov_pkg::*;
(
    input  logic                      clk_33,
    input  logic                      nrst,
    input  logic                      start,
    input  slice_pos_t                pos,
    output logic [ram_addr_width-1:0] ram_addr,
    input  pixel_t                    ram_data,
    output logic                      wr_en,
    output logic [idx_width-1:0]      wr_idx,
    output pixel_t                    wr_pixel,
    output logic                      swap
);

    // Address stage state
    logic                 busy;
    logic [idx_width-1:0] addr_cnt;
    logic                 last_addr;

    assign last_addr = busy && (addr_cnt == idx_width'(image_size - 1));

    // RAM data lines up with the delayed write index
    assign wr_pixel = ram_data;

    // Address generation, restarted by every start
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            busy <= 1'b0;
            addr_cnt <= '0;
            ram_addr <= '0;
        end else if (start) begin
            busy <= 1'b1;
            addr_cnt <= '0;
            ram_addr <= ram_addr_width'(pos) * ram_addr_width'(image_size)
                        + ram_addr_width'(ram_base);
        end else if (busy) begin
            if (last_addr) begin
                // Hold the last address once the slice is issued
                busy <= 1'b0;
            end else begin
                ram_addr <= ram_addr + 1'b1;
                addr_cnt <= addr_cnt + 1'b1;
            end
        end
    end

    // Write stage, one cycle behind for the RAM latency
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            wr_en <= 1'b0;
            wr_idx <= '0;
            swap <= 1'b0;
        end else begin
            wr_en <= busy;
            wr_idx <= addr_cnt;
            // Only a fully written slice goes on display
            swap <= wr_en && (wr_idx == idx_width'(image_size - 1));
        end
    end

    a_wr_idx_range: assert property (@(posedge clk_33) disable iff (!nrst)
        wr_en |-> wr_idx < idx_width'(image_size));

endmodule

//--- rtl/slice_buffer.sv
`timescale 1ns/1ps

module slice_buffer
    import pov_pkg::*;
(
    input  logic                 clk_33,
    input  logic                 nrst,
    input  logic                 wr_en,
    input  logic [idx_width-1:0] wr_idx,
    input  pixel_t               wr_pixel,
    input  logic                 swap,
    input  logic [idx_width-1:0] rd_idx,
    output pixel_t               rd_pixel
);

    // Two slice banks, one filling and one on display
    pixel_t mem [2][image_size];
    logic   fill_bank;
    logic   wr_bank;

    // A write during the swap cycle already belongs to the next fill
    assign wr_bank = swap ? ~fill_bank : fill_bank;

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            fill_bank <= 1'b0;
            rd_pixel <= '0;
            // Display starts from a dark slice
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < image_size; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            if (swap) begin
                fill_bank <= ~fill_bank;
            end
            if (wr_en) begin
                mem[wr_bank][wr_idx] <= wr_pixel;
            end
            // Registered read from the display bank
            rd_pixel <= mem[~fill_bank][rd_idx];
        end
    end

    // Only a restarted fetch can overlap the swap, with its first pixel
    a_swap_write: assert property (@(posedge clk_33) disable iff (!nrst)
        (wr_en && swap) |-> wr_idx == '0);

    a_rd_range: assert property (@(posedge clk_33) disable iff (!nrst)
        rd_idx < idx_width'(image_size));

endmodule

//--- rtl/bitplane_scanner.sv
`timescale 1ns/1ps

module bitplane_scanner
    import pov_pkg::*;
(
    input  logic                 clk_33,
    input  logic                 nrst,
    output logic [idx_width-1:0] rd_idx,
    input  pixel_t               rd_pixel,
    output scan_word_t           word,
    output logic                 word_valid,
    input  logic                 credit_return
);

    // Scan position, outer to inner
    logic [$clog2(multiplexing)-1:0]   col;
    logic [$clog2(poker_mode)-1:0]     slot;
    logic [$clog2(led_per_driver)-1:0] led;
    logic [1:0]                        colour;

    // Read issue and capture, one driver per cycle
    logic                             issuing;
    logic [$clog2(num_drivers)-1:0]   drv_cnt;
    logic                             cap_valid;
    logic [$clog2(num_drivers)-1:0]   cap_drv;
    logic [num_drivers-1:0]           asm_bits;
    logic                             full;

    logic [credit_width-1:0] credits;
    logic                    send;

    // Bit of one colour in one slot, low slots padded with zero
    function automatic logic plane_bit(input pixel_t p, input logic [3:0] s,
                                       input logic [1:0] c);
        logic b;
        b = 1'b0;
        if (c == colour_green && s >= 3) begin
            b = p.rgb.green[s - 3];
        end else if (c == colour_red && s >= 4) begin
            b = p.rgb.red[s - 4];
        end else if (c == colour_blue && s >= 4) begin
            b = p.rgb.blue[s - 4];
        end
        return b;
    endfunction

    // Pixel of the current driver, column and LED
    assign rd_idx = driver_base(drv_cnt) + idx_width'(2 * col)
                    + idx_width'(led) * idx_width'(row_size);

    // Word leaves only when complete and paid for
    assign send = full && (credits != '0);

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            col <= '0;
            slot <= 4'(poker_mode - 1);
            led <= '0;
            colour <= colour_red;
            issuing <= 1'b1;
            drv_cnt <= '0;
            cap_valid <= 1'b0;
            cap_drv <= '0;
            full <= 1'b0;
            credits <= credit_width'(fifo_depth);
            word_valid <= 1'b0;
        end else begin
            cap_valid <= issuing;
            cap_drv <= drv_cnt;
            if (issuing) begin
                // Index parks on the last driver while the word waits
                if (drv_cnt == num_drivers - 1) begin
                    issuing <= 1'b0;
                end else begin
                    drv_cnt <= drv_cnt + 1'b1;
                end
            end
            if (cap_valid && cap_drv == num_drivers - 1) begin
                full <= 1'b1;
            end
            word_valid <= send;
            if (send) begin
                // Next word, counters stay put while stalled
                full <= 1'b0;
                issuing <= 1'b1;
                drv_cnt <= '0;
                colour <= colour + 1'b1;
                if (colour == colour_blue) begin
                    colour <= colour_red;
                    led <= led + 1'b1;
                    if (led == led_per_driver - 1) begin
                        led <= '0;
                        slot <= slot - 1'b1;
                        if (slot == 0) begin
                            slot <= 4'(poker_mode - 1);
                            col <= (col == multiplexing - 1) ? '0 : col + 1'b1;
                        end
                    end
                end
            end
            case ({send, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    // Word payload
    always_ff @(posedge clk_33) begin
        if (cap_valid) begin
            asm_bits[cap_drv] <= plane_bit(rd_pixel, slot, colour);
        end
        if (send) begin
            word.bits <= asm_bits;
            // Closes the 48 words of one bit slot
            word.last_of_plane <= (led == led_per_driver - 1) && (colour == colour_blue);
        end
    end

    a_credit_max: assert property (@(posedge clk_33) disable iff (!nrst)
        credits <= credit_width'(fifo_depth));

    // Controller never returns more than was spent
    a_credit_return: assert property (@(posedge clk_33) disable iff (!nrst)
        credit_return |-> credits < credit_width'(fifo_depth) || send);

endmodule

//--- rtl/driver_main_controller.sv
`timescale 1ns/1ps

module driver_main_controller
    import pov_pkg::*;
(
    input  logic       clk_33,
    input  logic       nrst,
    input  scan_word_t word,
    input  logic       word_valid,
    output logic       credit_return,
    input  logic       chain_credit,
    output scan_word_t drv_word,
    output logic       drv_valid,
    output logic       lat
);

    // Word FIFO
    scan_word_t                  mem [fifo_depth];
    logic [fifo_ptr_width-1:0]   wr_ptr;
    logic [fifo_ptr_width-1:0]   rd_ptr;
    logic [credit_width-1:0]     count;

    // Credits granted by the external chain
    logic [ext_credit_width-1:0] ext_credits;
    logic                        pop;

    // Pop needs a stored word and a chain credit
    assign pop = (count != '0) && (ext_credits != '0);

    // Storage and output word
    always_ff @(posedge clk_33) begin
        if (word_valid) begin
            mem[wr_ptr] <= word;
        end
        if (pop) begin
            drv_word <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            ext_credits <= '0;
            drv_valid <= 1'b0;
            credit_return <= 1'b0;
            lat <= 1'b0;
        end else begin
            if (word_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + credit_width'(word_valid) - credit_width'(pop);
            ext_credits <= ext_credits + ext_credit_width'(chain_credit)
                           - ext_credit_width'(pop);
            drv_valid <= pop;
            // Freed slot goes back to the scanner
            credit_return <= pop;
            // Latch one cycle after the plane's last word
            lat <= drv_valid && drv_word.last_of_plane;
        end
    end

    // Scanner credits keep the FIFO from overflowing
    a_no_overflow: assert property (@(posedge clk_33) disable iff (!nrst)
        word_valid |-> count < credit_width'(fifo_depth));

    a_ext_credit_wrap: assert property (@(posedge clk_33) disable iff (!nrst)
        chain_credit |-> ext_credits != '1);

endmodule

//--- rtl/pov_display_top.sv
`timescale 1ns/1ps

module pov_display_top
    import pov_pkg::*;
(
    input  logic                      clk_33,
    input  logic                      nrst,
    input  logic                      enc_sync,
    input  slice_pos_t                enc_position,
    output logic [ram_addr_width-1:0] ram_addr,
    input  pixel_t                    ram_data,
    input  logic                      chain_credit,
    output scan_word_t                drv_word,
    output logic                      drv_valid,
    output logic                      lat
);

    // Encoder to fetch
    logic       start;
    slice_pos_t pos;

    // Fetch to buffer
    logic                 wr_en;
    logic [idx_width-1:0] wr_idx;
    pixel_t               wr_pixel;
    logic                 swap;

    // Buffer to scanner
    logic [idx_width-1:0] rd_idx;
    pixel_t               rd_pixel;

    // Scanner to controller credit loop
    scan_word_t word;
    logic       word_valid;
    logic       credit_return;

    encoder_tracker u_encoder_tracker (
        .clk_33, .nrst, .enc_sync, .enc_position, .start, .pos
    );

    slice_fetch u_slice_fetch (
        .clk_33, .nrst, .start, .pos, .ram_addr, .ram_data,
        .wr_en, .wr_idx, .wr_pixel, .swap
    );

    slice_buffer u_slice_buffer (
        .clk_33, .nrst, .wr_en, .wr_idx, .wr_pixel, .swap, .rd_idx, .rd_pixel
    );

    bitplane_scanner u_bitplane_scanner (
        .clk_33, .nrst, .rd_idx, .rd_pixel, .word, .word_valid, .credit_return
    );

    driver_main_controller u_driver_main_controller (
        .clk_33, .nrst, .word, .word_valid, .credit_return,
        .chain_credit, .drv_word, .drv_valid, .lat
    );

endmodule

//--- tests/tb_pov_display.sv
`timescale 1ns/1ps

module tb_pov_display
    import pov_pkg::*;
();

    logic                      clk_33 = 1'b0;
    logic                      nrst;
    logic                      enc_sync;
    slice_pos_t                enc_position;
    logic [ram_addr_width-1:0] ram_addr;
    pixel_t                    ram_data;
    logic                      chain_credit;
    scan_word_t                drv_word;
    logic                      drv_valid;
    logic                      lat;

    // Reference model state
    int                        word_cnt;
    int                        credits_given;
    int                        cycle_cnt;
    int                        addr_checks;
    int                        addr_left;
    int                        strobe_wait;
    int                        strobe_seq;
    int                        seen_seq;
    logic [ram_addr_width-1:0] addr_exp;
    logic [ram_addr_width-1:0] strobe_base;
    logic [ram_addr_width-1:0] ram_prev;
    logic                      lat_exp;
    logic                      started_any;
    logic                      credit_on;

    // Displayed slice per word index, -1 is the dark slice
    int old_slice;
    int new_slice;
    int switch_at;

    logic [num_drivers-1:0] exp_bits;
    logic                   exp_last;

    // Error counts by kind
    int fetch_err;
    int word_err;
    int lat_err;
    int credit_err;
    int other_err;

    pov_display_top DUT (
        .clk_33, .nrst, .enc_sync, .enc_position, .ram_addr, .ram_data,
        .chain_credit, .drv_word, .drv_valid, .lat
    );

    initial begin
        forever #20 clk_33 = ~clk_33;
    end

    // Pixel content of one RAM address
    function automatic logic [15:0] ram_mix(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:16] ^ a[15:0];
    endfunction

    function automatic logic [15:0] model_pixel(input int slice, input int idx);
        logic [31:0] a;
        if (slice < 0) begin
            return 16'h0000;
        end
        a = 32'(slice) * 32'(image_size) + 32'(ram_base) + 32'(idx);
        return ram_mix(a);
    endfunction

    // Colour bit shown in one bit slot, zero below the colour's MSB window
    function automatic logic slot_bit(input logic [15:0] pix, input int slot, input int colour);
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
        red = pix[15:11];
        green = pix[10:5];
        blue = pix[4:0];
        if (colour == 1) begin
            return (slot >= 3) ? green[slot - 3] : 1'b0;
        end
        if (slot < 4) begin
            return 1'b0;
        end
        return (colour == 0) ? red[slot - 4] : blue[slot - 4];
    endfunction

    // Word n of the scan: colour inner, then LED, then slot 8..0, then column
    function automatic logic [num_drivers-1:0] expected_bits(input int n, input int old_s,
                                                           input int new_s, input int sw);
        int slice;
        int per_plane;
        int per_col;
        int col;
        int slot;
        int led;
        logic [num_drivers-1:0] bits;
        per_plane = led_per_driver * 3;
        per_col = per_plane * poker_mode;
        slice = (n >= sw) ? new_s : old_s;
        col = (n / per_col) % multiplexing;
        slot = poker_mode - 1 - (n % per_col) / per_plane;
        led = (n % per_plane) / 3;
        for (int i = 0; i < num_drivers; i++) begin
            bits[i] = slot_bit(model_pixel(slice, int'(driver_base(i)) + 2 * col
                                           + led * row_size), slot, n % 3);
        end
        return bits;
    endfunction

    assign exp_bits = expected_bits(word_cnt, old_slice, new_slice, switch_at);
    assign exp_last = (word_cnt % (led_per_driver * 3)) == (led_per_driver * 3 - 1);

    // RAM with one cycle of read latency
    initial begin
        ram_data = '0;
        ram_prev = '0;
        forever begin
            @(negedge clk_33);
            ram_data.raw = ram_mix(ram_prev);
            ram_prev = ram_addr;
        end
    end

    // Word, credit, latch and fetch address tracking
    always @(posedge clk_33) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!nrst) begin
            word_cnt <= 0;
            credits_given <= 0;
            lat_exp <= 1'b0;
            addr_left <= 0;
            strobe_wait <= 0;
            seen_seq <= 0;
            addr_checks <= 0;
        end else begin
            if (drv_valid) begin
                word_cnt <= word_cnt + 1;
            end
            if (chain_credit) begin
                credits_given <= credits_given + 1;
            end
            lat_exp <= drv_valid && exp_last;
            if (addr_left != 0) begin
                addr_left <= addr_left - 1;
                addr_exp <= addr_exp + 32'd1;
                addr_checks <= addr_checks + 1;
            end
            // Strobe reaches the address bus on the 4th edge, overriding a running fetch
            if (strobe_wait != 0) begin
                strobe_wait <= strobe_wait - 1;
                if (strobe_wait == 1) begin
                    addr_exp <= strobe_base;
                    addr_left <= image_size;
                end
            end
            if (strobe_seq != seen_seq) begin
                seen_seq <= strobe_seq;
                strobe_wait <= 3;
            end
        end
    end

    reset_idle: assert property (@(posedge clk_33)
        (!nrst && cycle_cnt > 1) |-> !drv_valid && !lat)
        else begin
            fetch_err++;
            $display("Error at %0t: drv_valid/lat expected 0/0 actual %b/%b", $time,
                     $sampled(drv_valid), $sampled(lat));
        end

    fetch_idle: assert property (@(posedge clk_33) disable iff (!nrst)
        !started_any |-> ram_addr == '0)
        else begin
            fetch_err++;
            $display("Error at %0t: ram_addr expected 0 actual %h", $time, $sampled(ram_addr));
        end

    fetch_addr: assert property (@(posedge clk_33) disable iff (!nrst)
        addr_left != 0 |-> ram_addr == addr_exp)
        else begin
            fetch_err++;
            $display("Error at %0t: ram_addr expected %h actual %h", $time,
                     $sampled(addr_exp), $sampled(ram_addr));
        end

    word_bits: assert property (@(posedge clk_33) disable iff (!nrst)
        drv_valid |-> drv_word.bits == exp_bits)
        else begin
            word_err++;
            $display("Error at %0t: drv_word.bits expected %h actual %h", $time,
                     $sampled(exp_bits), $sampled(drv_word.bits));
        end

    word_last: assert property (@(posedge clk_33) disable iff (!nrst)
        drv_valid |-> drv_word.last_of_plane == exp_last)
        else begin
            word_err++;
            $display("Error at %0t: drv_word.last_of_plane expected %b actual %b", $time,
                     $sampled(exp_last), $sampled(drv_word.last_of_plane));
        end

    latch_pulse: assert property (@(posedge clk_33) disable iff (!nrst) lat == lat_exp)
        else begin
            lat_err++;
            $display("Error at %0t: lat expected %b actual %b", $time,
                     $sampled(lat_exp), $sampled(lat));
        end

    credit_bound: assert property (@(posedge clk_33) disable iff (!nrst)
        word_cnt <= credits_given)
        else begin
            credit_err++;
            $display("Error at %0t: drv_valid count expected at most %0d actual %0d", $time,
                     $sampled(credits_given), $sampled(word_cnt));
        end

    task automatic print_counts();
        $write("Counts: %0d words, %0d addresses; ", word_cnt, addr_checks);
        $display("errors fetch %0d word %0d latch %0d credit %0d other %0d",
                 fetch_err, word_err, lat_err, credit_err, other_err);
    endtask

    task automatic stop_on_timeout(input string what);
        other_err++;
        $display("Timeout: %s", what);
        print_counts();
        $display("test failed");
        $finish;
    endtask

    // Random chain credits, capped outstanding, with long droughts now and then
    task automatic pace_credits();
        int drought;
        drought = 0;
        forever begin
            @(negedge clk_33);
            chain_credit = 1'b0;
            if (drought > 0) begin
                drought--;
            end else if (credit_on && $urandom_range(499, 0) == 0) begin
                drought = 200 + int'($urandom_range(400, 0));
            end else if (credit_on && credits_given - word_cnt < 6
                         && $urandom_range(3, 0) == 0) begin
                chain_credit = 1'b1;
            end
        end
    endtask

    task automatic wait_words(input int count);
        int target;
        int t;
        target = word_cnt + count;
        t = 0;
        while (word_cnt < target && t < count * 200 + 2000) begin
            @(negedge clk_33);
            t++;
        end
        if (word_cnt < target) begin
            stop_on_timeout("driver words stopped arriving");
        end
    endtask

    task automatic wait_fetch_below(input int limit);
        int t;
        t = 0;
        while (addr_left >= limit && t < 6000) begin
            @(negedge clk_33);
            t++;
        end
        if (addr_left >= limit) begin
            stop_on_timeout("fetch addresses did not advance");
        end
    endtask

    // Encoder strobe after a random gap, held high a random few cycles
    task automatic strobe_slice(input int p);
        int t;
        repeat ($urandom_range(20, 3)) @(negedge clk_33);
        enc_position = slice_pos_t'(p);
        enc_sync = 1'b1;
        started_any = 1'b1;
        strobe_base = 32'(p) * 32'(image_size) + 32'(ram_base);
        strobe_seq++;
        repeat ($urandom_range(5, 2)) @(negedge clk_33);
        enc_sync = 1'b0;
        t = 0;
        while ((strobe_seq != seen_seq || strobe_wait != 0) && t < 50) begin
            @(negedge clk_33);
            t++;
        end
        if (strobe_seq != seen_seq || strobe_wait != 0) begin
            stop_on_timeout("encoder strobe never reached the fetch model");
        end
    endtask

    // Freeze the output ahead of the swap so the switch lands on a known word
    task automatic finish_fetch(input int p);
        int t;
        int idle;
        wait_fetch_below(1500);
        credit_on = 1'b0;
        t = 0;
        idle = 0;
        while (idle < 300 && t < 3000) begin
            @(negedge clk_33);
            t++;
            idle = drv_valid ? 0 : idle + 1;
        end
        if (idle < 300) begin
            stop_on_timeout("driver output did not stop without chain credits");
        end
        if (addr_left == 0) begin
            other_err++;
            $display("Fetch of slice %0d ended before the output had stopped", p);
        end
        // Full FIFO plus the assembled word still hold the old slice
        old_slice = new_slice;
        new_slice = p;
        switch_at = word_cnt + fifo_depth + 1;
        wait_fetch_below(1);
        repeat (8) @(negedge clk_33);
        credit_on = 1'b1;
    endtask

    initial begin
        void'($urandom(94));
        nrst = 1'b0;
        enc_sync = 1'b0;
        enc_position = '0;
        chain_credit = 1'b0;
        cycle_cnt = 0;
        strobe_seq = 0;
        strobe_base = '0;
        addr_exp = '0;
        started_any = 1'b0;
        credit_on = 1'b0;
        old_slice = -1;
        new_slice = -1;
        switch_at = 0;
        fetch_err = 0;
        word_err = 0;
        lat_err = 0;
        credit_err = 0;
        other_err = 0;
        repeat (16) @(negedge clk_33);
        nrst = 1'b1;
        fork
            pace_credits();
        join_none
        credit_on = 1'b1;
        // Dark display before any swap
        wait_words(150);
        strobe_slice(5);
        finish_fetch(5);
        wait_words(1000);
        // Restart in mid fetch, slice 5 stays on display meanwhile
        strobe_slice(9);
        wait_fetch_below(2000);
        strobe_slice(12);
        finish_fetch(12);
        wait_words(600);
        print_counts();
        if (fetch_err + word_err + lat_err + credit_err + other_err == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/pov_pkg.sv
rtl/encoder_tracker.sv
rtl/slice_fetch.sv
rtl/slice_buffer.sv
rtl/bitplane_scanner.sv
rtl/driver_main_controller.sv
rtl/pov_display_top.sv
tests/tb_pov_display.sv

//--- Makefile
# Verilator build and run of the POV display testbench
TOP = tb_pov_display
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
